//--- axi_ram_model.f
+incdir+testbench
source/axi_pkg.sv
source/ram_pkg.sv
source/ram_timing.sv
source/ram_burst_addr.sv
source/ram_storage.sv
source/axi_ram_model.sv
testbench/tb_axi_ram_model.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator; the result comes from the printed pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_axi_ram_model -f axi_ram_model.f &&
./obj_dir/Vtb_axi_ram_model | tee /dev/stderr | grep -x "PASS: all tests" > /dev/null &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

//--- source/axi_pkg.sv
package axi_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int LEN_W  = 8;
    localparam int SIZE_W = 3;

    typedef logic [ADDR_W-1:0] addr_t;     // Byte address
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;     // One bit per byte lane
    typedef logic [LEN_W-1:0]  len_t;      // Beats minus one
    typedef logic [SIZE_W-1:0] size_t;     // Log2 of bytes per beat

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10                // 2'b11 reserved
    } burst_e;

    // Shared by AR and AW
    typedef struct packed {
        addr_t  addr;
        len_t   len;
        size_t  size;
        burst_e burst;
    } ax_t;

    typedef struct packed {
        data_t  data;
        strb_t  strb;
        logic   last;
    } w_t;

endpackage

//--- source/axi_ram_model.sv
module axi_ram_model #(
    parameter ram_pkg::delay_t R_DELAY = ram_pkg::R_DELAY_DEF,
    parameter ram_pkg::delay_t W_DELAY = ram_pkg::W_DELAY_DEF
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic            stall,

    input  axi_pkg::ax_t    ar,
    input  logic            arvalid,
    output logic            arready,

    output axi_pkg::data_t  rdata,
    output logic            rlast,
    output logic            rvalid,
    input  logic            rready,

    input  axi_pkg::ax_t    aw,
    input  logic            awvalid,
    output logic            awready,

    input  axi_pkg::w_t     w,
    input  logic            wvalid,
    output logic            wready,

    output logic            bvalid,
    input  logic            bready
);
    import ram_pkg::*;

    logic ar_start;
    logic aw_start;
    logic r_beat;
    logic w_beat;
    idx_t rd_idx;
    idx_t wr_idx;

    ram_timing #(
        .R_DELAY (R_DELAY),
        .W_DELAY (W_DELAY)
    ) timing (
        .clk      (clk),
        .resetn   (resetn),
        .stall    (stall),
        .arvalid  (arvalid),
        .arready  (arready),
        .ar_len   (ar.len),
        .rvalid   (rvalid),
        .rready   (rready),
        .rlast    (rlast),
        .awvalid  (awvalid),
        .awready  (awready),
        .wvalid   (wvalid),
        .wready   (wready),
        .wlast    (w.last),
        .bvalid   (bvalid),
        .bready   (bready),
        .ar_start (ar_start),
        .aw_start (aw_start),
        .r_beat   (r_beat),
        .w_beat   (w_beat)
    );

    ram_burst_addr rd_addr (
        .clk    (clk),
        .resetn (resetn),
        .stall  (stall),
        .start  (ar_start),
        .beat   (r_beat),
        .ax     (ar),
        .idx    (rd_idx)
    );

    ram_burst_addr wr_addr (
        .clk    (clk),
        .resetn (resetn),
        .stall  (stall),
        .start  (aw_start),
        .beat   (w_beat),
        .ax     (aw),
        .idx    (wr_idx)
    );

    ram_storage storage (
        .clk    (clk),
        .we     (w_beat),
        .widx   (wr_idx),
        .wdata  (w.data),
        .wstrb  (w.strb),
        .ridx   (rd_idx),
        .rdata  (rdata)
    );

endmodule

//--- source/ram_burst_addr.sv
module ram_burst_addr (
    input  logic            clk,
    input  logic            resetn,
    input  logic            stall,
    input  logic            start,
    input  logic            beat,
    input  axi_pkg::ax_t    ax,
    output ram_pkg::idx_t   idx
);
    import axi_pkg::*;
    import ram_pkg::*;

    ax_t   cur;            // Burst in progress with addr at the current beat
    addr_t step;
    addr_t wrap_mask;
    addr_t next_addr;

    assign step      = addr_t'(1) << cur.size;
    assign wrap_mask = ((addr_t'(cur.len) + addr_t'(1)) << cur.size) - addr_t'(1);

    always_comb begin
        case (cur.burst)
            BURST_FIXED: next_addr = cur.addr;
            BURST_INCR:  next_addr = cur.addr + step;
            BURST_WRAP: begin
                // Stay inside the aligned block of (len+1) beats
                next_addr = (cur.addr & ~wrap_mask) | ((cur.addr + step) & wrap_mask);
            end
            default:     next_addr = cur.addr + step;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cur <= '0;
        end else if (!stall) begin
            if (start)
                cur <= ax;
            else if (beat)
                cur.addr <= next_addr;
        end
    end

    assign idx = cur.addr[WORD_SHIFT +: IDX_W];    // Wraps at MEM_WORDS

endmodule

//--- source/ram_pkg.sv
package ram_pkg;

    localparam int MEM_WORDS  = 4096;
    localparam int IDX_W      = $clog2(MEM_WORDS);
    localparam int WORD_SHIFT = 2;         // Bytes per word is 4
    localparam int DELAY_W    = 16;

    typedef logic [IDX_W-1:0]   idx_t;     // Word index into the array
    typedef logic [DELAY_W-1:0] delay_t;   // Latency counter

    localparam delay_t R_DELAY_DEF = 16'd25;
    localparam delay_t W_DELAY_DEF = 16'd3;

endpackage

//--- source/ram_storage.sv
module ram_storage (
    input  logic            clk,
    input  logic            we,
    input  ram_pkg::idx_t   widx,
    input  axi_pkg::data_t  wdata,
    input  axi_pkg::strb_t  wstrb,
    input  ram_pkg::idx_t   ridx,
    output axi_pkg::data_t  rdata
);
    import axi_pkg::*;
    import ram_pkg::*;

    data_t mem [MEM_WORDS];

    // Only enabled byte lanes change
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wstrb[b])
                    mem[widx][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

    assign rdata = mem[ridx];      // Valid in the same cycle as rvalid

endmodule

//--- source/ram_timing.sv
module ram_timing #(
    parameter ram_pkg::delay_t R_DELAY = ram_pkg::R_DELAY_DEF,
    parameter ram_pkg::delay_t W_DELAY = ram_pkg::W_DELAY_DEF
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic            stall,

    input  logic            arvalid,
    output logic            arready,
    input  axi_pkg::len_t   ar_len,

    output logic            rvalid,
    input  logic            rready,
    output logic            rlast,

    input  logic            awvalid,
    output logic            awready,

    input  logic            wvalid,
    output logic            wready,
    input  logic            wlast,

    output logic            bvalid,
    input  logic            bready,

    output logic            ar_start,
    output logic            aw_start,
    output logic            r_beat,
    output logic            w_beat
);
    import axi_pkg::*;
    import ram_pkg::*;

    logic   rd_busy;       // Read burst in flight
    len_t   rlen;          // Beats left minus one
    delay_t rcnt;

    logic   aw_busy;       // Write address held
    logic   w_done;        // Last write beat seen
    delay_t wcnt;

    logic   b_done;

    // All outputs drop while stalled, so no handshake can complete
    assign arready  = !rd_busy && !stall;
    assign rvalid   = rd_busy && rcnt == '0 && !stall;
    assign rlast    = rvalid && rlen == '0;
    assign awready  = !aw_busy && !stall;
    assign wready   = aw_busy && !w_done && !stall;
    assign bvalid   = aw_busy && w_done && wcnt == '0 && !stall;

    assign ar_start = arvalid && arready;
    assign aw_start = awvalid && awready;
    assign r_beat   = rvalid && rready;
    assign w_beat   = wvalid && wready;
    assign b_done   = bvalid && bready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_busy <= 1'b0;
            rlen    <= '0;
            rcnt    <= '0;
        end else if (!stall) begin
            if (ar_start) begin
                rd_busy <= 1'b1;
                rlen    <= ar_len;
                rcnt    <= R_DELAY;
            end else begin
                if (rcnt != '0)
                    rcnt <= rcnt - delay_t'(1);
                if (r_beat) begin
                    rlen <= rlen - len_t'(1);
                    if (rlen == '0)
                        rd_busy <= 1'b0;           // Last beat out
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            aw_busy <= 1'b0;
            w_done  <= 1'b0;
            wcnt    <= '0;
        end else if (!stall) begin
            if (aw_start) begin
                aw_busy <= 1'b1;
                w_done  <= 1'b0;
            end else if (b_done) begin
                aw_busy <= 1'b0;
                w_done  <= 1'b0;
            end else if (w_beat && wlast) begin
                w_done  <= 1'b1;
                wcnt    <= W_DELAY;            // Count from the last beat
            end else if (wcnt != '0) begin
                wcnt    <= wcnt - delay_t'(1);
            end
        end
    end

endmodule

//--- testbench/tb_axi_ram_ref.svh
`ifndef TB_AXI_RAM_REF_SVH
`define TB_AXI_RAM_REF_SVH

// Expected memory contents that each accepted W beat updates
data_t shadow [MEM_WORDS];

// Byte address of beat n within a burst
function automatic addr_t beat_addr(ax_t a, int unsigned n);
    addr_t bytes;
    addr_t block;
    addr_t base;
    bytes = addr_t'(1) << a.size;
    case (a.burst)
        BURST_FIXED: return a.addr;
        BURST_WRAP: begin
            block = bytes * (addr_t'(a.len) + addr_t'(1));    // Wrap boundary size
            base  = (a.addr / block) * block;
            return base + ((a.addr - base + bytes * addr_t'(n)) % block);
        end
        default: return a.addr + bytes * addr_t'(n);
    endcase
endfunction

function automatic idx_t word_of(addr_t addr);
    return idx_t'((addr >> 2) % MEM_WORDS);
endfunction

// Byte lanes that a beat of this size uses at this address
function automatic strb_t lane_mask(addr_t addr, size_t size);
    int unsigned bytes;
    int unsigned lo;
    strb_t       m;
    bytes = 1 << size;
    lo    = addr % 4;
    m     = '0;
    for (int b = 0; b < STRB_W; b++) begin
        if (b >= lo && b < lo + bytes)
            m[b] = 1'b1;
    end
    return m;
endfunction

function automatic data_t apply_strobe(data_t old, data_t wdata, strb_t strb);
    data_t r;
    r = old;
    for (int b = 0; b < STRB_W; b++) begin
        if (strb[b])
            r[b*8 +: 8] = wdata[b*8 +: 8];
    end
    return r;
endfunction

`endif

//--- testbench/tb_axi_ram_model.sv
module tb_axi_ram_model;
    timeunit 1ns;
    timeprecision 1ps;

    import axi_pkg::*;
    import ram_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int STALL_K    = 6;
    localparam int N_BEATS    = 62;        // W and R beats of all tests
    localparam int N_READS    = 9;
    localparam int N_WRITES   = 9;
    localparam int WATCHDOG_NS = (N_BEATS + N_READS * int'(R_DELAY_DEF)
                                 + N_WRITES * int'(W_DELAY_DEF) + 2 * STALL_K)
                                 * 2 * CLK_PERIOD;

    logic  clk;
    logic  resetn;
    logic  stall;
    ax_t   ar;
    logic  arvalid;
    logic  arready;
    data_t rdata;
    logic  rlast;
    logic  rvalid;
    logic  rready;
    ax_t   aw;
    logic  awvalid;
    logic  awready;
    w_t    w;
    logic  wvalid;
    logic  wready;
    logic  bvalid;
    logic  bready;

    int    errors;
    int    checks;
    data_t exp_data [$];
    logic  exp_last [$];

    `include "tb_axi_ram_ref.svh"

    axi_ram_model dut0 (
        .clk     (clk),
        .resetn  (resetn),
        .stall   (stall),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_data(input string name, input data_t exp, input data_t act);
        checks++;
        if (act !== exp) begin
            $display("Error: %s expected %h got %h at %0t", name, exp, act, $time);
            errors++;
        end
    endtask

    task automatic check_last(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            $display("Error: %s expected %h got %h at %0t", name, exp, act, $time);
            errors++;
        end
    endtask

    task automatic check_latency(input string name, input delay_t exp, input delay_t act);
        checks++;
        if (act !== exp) begin
            $display("Error: %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    function automatic ax_t make_ax(addr_t addr, len_t len, size_t size, burst_e burst);
        ax_t a;
        a.addr  = addr;
        a.len   = len;
        a.size  = size;
        a.burst = burst;
        return a;
    endfunction

    // Counts the cycles before the sampled flag rises and stalls the first k of them
    task automatic wait_latency(input bit for_read, input int stall_k, output delay_t lat);
        int sc;
        lat   = '0;
        sc    = 0;
        stall = (stall_k > 0);
        @(negedge clk);
        while (!(for_read ? rvalid : bvalid)) begin
            lat = lat + 16'd1;
            @(posedge clk);
            #2;
            sc++;
            if (sc >= stall_k)
                stall = 1'b0;
            @(negedge clk);
        end
    endtask

    task automatic write_burst(input ax_t a, input bit rand_strb, input int stall_k,
                               output delay_t lat);
        addr_t ba;
        idx_t  wi;
        data_t d;
        strb_t s;
        @(posedge clk);
        #2;
        aw      = a;
        awvalid = 1'b1;
        do @(negedge clk); while (!awready);
        @(posedge clk);
        #2;
        awvalid = 1'b0;
        for (int n = 0; n <= int'(a.len); n++) begin
            ba = beat_addr(a, n);
            s  = lane_mask(ba, a.size);
            if (rand_strb)
                s = s & strb_t'($urandom);
            d      = $urandom;
            w.data = d;
            w.strb = s;
            w.last = (n == int'(a.len));
            wvalid = 1'b1;
            do @(negedge clk); while (!wready);
            wi         = word_of(ba);
            shadow[wi] = apply_strobe(shadow[wi], d, s);
            @(posedge clk);
            #2;
        end
        wvalid = 1'b0;
        wait_latency(1'b0, stall_k, lat);
        @(posedge clk);            // B transfer
        #2;
    endtask

    task automatic read_burst(input ax_t a, input bit rand_ready, input int stall_k,
                              output delay_t lat);
        bit done;
        for (int n = 0; n <= int'(a.len); n++) begin
            exp_data.push_back(shadow[word_of(beat_addr(a, n))]);
            exp_last.push_back(n == int'(a.len));
        end
        @(posedge clk);
        #2;
        ar      = a;
        arvalid = 1'b1;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        #2;
        arvalid = 1'b0;
        rready  = 1'b1;
        wait_latency(1'b1, stall_k, lat);
        done = 1'b0;
        while (!done) begin
            if (rvalid && rready && rlast) begin
                done = 1'b1;
            end else begin
                @(posedge clk);
                #2;
                rready = rand_ready ? ($urandom_range(3) != 0) : 1'b1;
                @(negedge clk);
            end
        end
        @(posedge clk);
        #2;
        rready = 1'b0;
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        if (exp_data.size() != 0) begin
            report_problem($sformatf("Error: %0d expected R beats never arrived",
                                     exp_data.size()));
            exp_data.delete();
            exp_last.delete();
        end
        $display("test %0d %s: %0d errors", num, name, errors - err_before);
    endtask

    // R beat checker and stall monitor
    initial begin
        forever begin
            @(negedge clk);
            if (resetn && stall && (arready || rvalid || awready || wready || bvalid))
                report_problem("Error: a ready or valid output was high during stall");
            if (resetn && rvalid && rready) begin
                if (exp_data.size() == 0) begin
                    report_problem("Error: R beat arrived with no read outstanding");
                end else begin
                    check_data("rdata", exp_data.pop_front(), rdata);
                    check_last("rlast", exp_last.pop_front(), rlast);
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        delay_t lat;
        ax_t    a;
        int     e0;
        resetn  = 1'b0;
        stall   = 1'b0;
        ar      = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        aw      = '0;
        awvalid = 1'b0;
        w       = '0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        errors  = 0;
        checks  = 0;
        void'($urandom(32'h1b8f));
        repeat (8) @(posedge clk);
        #2;
        resetn = 1'b1;

        e0 = errors;
        a  = make_ax(32'h100, 8'd0, 3'd2, BURST_INCR);
        write_burst(a, 1'b0, 0, lat);
        read_burst(a, 1'b0, 0, lat);
        report_test(1, "single beat", e0);

        e0 = errors;
        a  = make_ax(32'h200, 8'd7, 3'd2, BURST_INCR);
        write_burst(a, 1'b0, 0, lat);          // Fill every byte first
        write_burst(a, 1'b1, 0, lat);
        read_burst(a, 1'b1, 0, lat);
        report_test(2, "incr strobes backpressure", e0);

        e0 = errors;
        a  = make_ax(32'h308, 8'd3, 3'd2, BURST_WRAP);
        write_burst(a, 1'b0, 0, lat);
        read_burst(a, 1'b0, 0, lat);
        read_burst(make_ax(32'h300, 8'd3, 3'd2, BURST_INCR), 1'b0, 0, lat);
        report_test(3, "wrap", e0);

        e0 = errors;
        write_burst(make_ax(32'h400, 8'd0, 3'd2, BURST_INCR), 1'b0, 0, lat);
        write_burst(make_ax(32'h400, 8'd3, 3'd2, BURST_FIXED), 1'b1, 0, lat);
        read_burst(make_ax(32'h400, 8'd0, 3'd2, BURST_INCR), 1'b0, 0, lat);
        a = make_ax(32'h500, 8'd3, 3'd1, BURST_INCR);     // Halfword beats
        write_burst(a, 1'b0, 0, lat);
        read_burst(a, 1'b0, 0, lat);
        read_burst(make_ax(32'h500, 8'd1, 3'd2, BURST_INCR), 1'b0, 0, lat);
        report_test(4, "fixed and narrow", e0);

        e0 = errors;
        a  = make_ax(32'h600, 8'd1, 3'd2, BURST_INCR);
        write_burst(a, 1'b0, 0, lat);
        check_latency("bvalid latency", W_DELAY_DEF, lat);
        read_burst(a, 1'b0, 0, lat);
        check_latency("rvalid latency", R_DELAY_DEF, lat);
        report_test(5, "latency", e0);

        e0 = errors;
        a  = make_ax(32'h700, 8'd1, 3'd2, BURST_INCR);
        write_burst(a, 1'b0, STALL_K, lat);
        check_latency("bvalid latency", W_DELAY_DEF + delay_t'(STALL_K), lat);
        read_burst(a, 1'b0, STALL_K, lat);
        check_latency("rvalid latency", R_DELAY_DEF + delay_t'(STALL_K), lat);
        report_test(6, "stall", e0);

        $display("6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule
